// ==== hw/regex_pkg.sv ====
`default_nettype none

package regex_pkg;

  // Number of interleaved streams tracked by the design
  parameter int NUM_STREAMS = 64;

  // Field widths
  localparam int CHAR_W      = 8;
  localparam int STREAM_ID_W = 6;
  localparam int DFA_STATE_W = 11;
  localparam int COUNT_W     = 16;

  // One payload byte
  typedef logic [CHAR_W-1:0] char_t;

  // Stream number as carried with sop
  typedef logic [STREAM_ID_W-1:0] stream_id_t;

  // Saved DFA state word
  // Sized for a larger DFA so the save memory can be reused
  typedef logic [DFA_STATE_W-1:0] dfa_state_t;

  // Matched packet count, wraps on overflow
  typedef logic [COUNT_W-1:0] match_count_t;

  // Keyword DFA states, progress through "RETR"
  // Accept is an output of the last step, not a state of its own
  typedef enum dfa_state_t {
    KW_IDLE = 11'd0,
    KW_R    = 11'd1,
    KW_RE   = 11'd2,
    KW_RET  = 11'd3
  } keyword_state_e;

  // Upper case ASCII letters of the keyword
  localparam char_t ASCII_R = 8'h52;
  localparam char_t ASCII_E = 8'h45;
  localparam char_t ASCII_T = 8'h54;

  // Bit that separates upper and lower case letters
  localparam char_t CASE_BIT = 8'h20;

endpackage : regex_pkg

`default_nettype wire

// ==== hw/dfa_step_if.sv ====
`default_nettype none

// Character and state-load path between the matcher and the DFA
interface dfa_step_if;
  import regex_pkg::*;

  char_t      char_in;
  logic       char_vld;
  dfa_state_t state_in;
  logic       state_vld;
  dfa_state_t state_out;
  logic       accept;

  // Matcher side, all four inputs of the DFA come from registers
  modport matcher (
    output char_in, char_vld, state_in, state_vld,
    input  state_out, accept
  );

  // DFA side
  modport dfa (
    input  char_in, char_vld, state_in, state_vld,
    output state_out, accept
  );

endinterface : dfa_step_if

// Per-packet stream context from the tracker to the matcher
interface track_if;
  import regex_pkg::*;

  logic       load_state;
  logic       new_stream;
  stream_id_t cur_stream;
  logic       pkt_enable;

  modport source (output load_state, new_stream, cur_stream, pkt_enable);
  modport sink   (input  load_state, new_stream, cur_stream, pkt_enable);

endinterface : track_if

`default_nettype wire

// ==== hw/retr_keyword_dfa.sv ====
`default_nettype none

module retr_keyword_dfa (
  input logic     clk,
  input logic     rst_n,
  dfa_step_if.dfa step
);
  import regex_pkg::*;

  keyword_state_e cur_state;
  keyword_state_e next_state;

  // Case-insensitive hits on the keyword letters
  logic hit_r;
  logic hit_e;
  logic hit_t;

  // True for the upper case letter or its lower case form
  function automatic logic char_is(input char_t c, input char_t upper);
    return (c == upper) || (c == (upper | CASE_BIT));
  endfunction

  always_comb
  begin
    hit_r = char_is(step.char_in, ASCII_R);
    hit_e = char_is(step.char_in, ASCII_E);
    hit_t = char_is(step.char_in, ASCII_T);
  end

  // Next state for the current character
  // An 'r' that breaks a partial match starts a new one
  always_comb
  begin
    case (cur_state)
      KW_IDLE:
        next_state = hit_r ? KW_R : KW_IDLE;
      KW_R:
        next_state = hit_e ? KW_RE : (hit_r ? KW_R : KW_IDLE);
      KW_RE:
        next_state = hit_t ? KW_RET : (hit_r ? KW_R : KW_IDLE);
      // Final 'r' completes the keyword, any other byte drops it
      // Both cases go back to idle
      KW_RET:
        next_state = KW_IDLE;
      // Unknown restored word, treat as idle
      default:
        next_state = KW_IDLE;
    endcase
  end

  // One-cycle accept pulse on the closing 'r' of "retr"
  assign step.accept = step.char_vld && (cur_state == KW_RET) && hit_r;

  // Current state register
  // A restore from the matcher wins over a character
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cur_state <= KW_IDLE;
    end
    else if (step.state_vld)
    begin
      cur_state <= keyword_state_e'(step.state_in);
    end
    else if (step.char_vld)
    begin
      cur_state <= next_state;
    end
  end

  // Saved by the matcher at end of packet
  assign step.state_out = cur_state;

endmodule : retr_keyword_dfa

`default_nettype wire

// ==== hw/stream_context_matcher.sv ====
`default_nettype none

module stream_context_matcher #(
  parameter int NUM_STREAMS = regex_pkg::NUM_STREAMS
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    eop,
  input  regex_pkg::char_t        char_in,
  input  logic                    char_vld,
  track_if.sink                   trk,
  dfa_step_if.matcher             dfa,
  output logic                    fired,
  output regex_pkg::match_count_t count
);
  import regex_pkg::*;

  localparam int IDX_W = $clog2(NUM_STREAMS);

  // Saved DFA state per stream, no reset, new streams bypass it
  dfa_state_t state_mem [NUM_STREAMS];

  // Memory address, the low bits of the current stream
  logic [IDX_W-1:0] mem_idx;

  // First stage of the restore path, the memory read
  dfa_state_t state_rd;
  logic       state_rd_vld;

  // DFA outputs registered for timing
  dfa_state_t state_out_r;
  logic       accept_r;

  assign mem_idx = trk.cur_stream[IDX_W-1:0];

  // Control registers on the restore, character and result paths
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_rd_vld  <= 1'b0;
      dfa.state_vld <= 1'b0;
      dfa.char_vld  <= 1'b0;
      accept_r      <= 1'b0;
    end
    else
    begin
      // load_state to state_vld is two cycles
      state_rd_vld  <= trk.load_state;
      dfa.state_vld <= state_rd_vld;
      dfa.char_vld  <= char_vld;
      accept_r      <= dfa.accept;
    end
  end

  // Payload registers next to the control ones
  always_ff @(posedge clk)
  begin
    // New stream starts from idle, others resume where they stopped
    if (trk.load_state)
    begin
      state_rd <= trk.new_stream ? dfa_state_t'(KW_IDLE) : state_mem[mem_idx];
    end
    dfa.state_in <= state_rd;
    dfa.char_in  <= char_in;
    state_out_r  <= dfa.state_out;
  end

  // Save the stream state at end of an enabled packet
  // state_out_r has settled by then, eop trails the last byte
  always_ff @(posedge clk)
  begin
    if (eop && trk.pkt_enable)
    begin
      state_mem[mem_idx] <= state_out_r;
    end
  end

  // Per-packet match flag and matched packet count
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      fired <= 1'b0;
      count <= '0;
    end
    else
    begin
      // Fresh flag for every packet
      if (trk.load_state)
      begin
        fired <= 1'b0;
      end

      // Any accept inside the packet marks it
      if (accept_r)
      begin
        fired <= 1'b1;
      end

      if (eop)
      begin
        if (trk.pkt_enable)
        begin
          // Enabled packet, count it if it matched
          count <= count + match_count_t'(fired);
        end
        else
        begin
          // Disabled packet leaves no trace
          fired <= 1'b0;
        end
      end
    end
  end

endmodule : stream_context_matcher

`default_nettype wire

// ==== hw/stream_tracker.sv ====
`default_nettype none

module stream_tracker #(
  parameter int NUM_STREAMS = regex_pkg::NUM_STREAMS
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sop,
  input  regex_pkg::stream_id_t stream_id,
  input  logic                 enable,
  track_if.source              trk
);

  localparam int IDX_W = $clog2(NUM_STREAMS);

  // One bit per stream, set once a packet of it has started
  logic [NUM_STREAMS-1:0] seen;

  // Seen table index for the incoming stream
  logic [IDX_W-1:0] sop_idx;

  assign sop_idx = stream_id[IDX_W-1:0];

  // Control side of the packet context
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      seen           <= '0;
      trk.load_state <= 1'b0;
      trk.new_stream <= 1'b0;
      trk.pkt_enable <= 1'b0;
    end
    else
    begin
      // Restore request one cycle after sop
      trk.load_state <= sop;

      if (sop)
      begin
        // New only if no packet of this stream came since reset
        trk.new_stream <= !seen[sop_idx];
        trk.pkt_enable <= enable;
        seen[sop_idx]  <= 1'b1;
      end
    end
  end

  // Stream number, held for the whole packet
  always_ff @(posedge clk)
  begin
    if (sop)
    begin
      trk.cur_stream <= stream_id;
    end
  end

endmodule : stream_tracker

`default_nettype wire

// ==== hw/regex_match_top.sv ====
`default_nettype none

module regex_match_top #(
  parameter int NUM_STREAMS = regex_pkg::NUM_STREAMS
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    sop,
  input  logic                    eop,
  input  regex_pkg::stream_id_t   stream_id,
  input  logic                    enable,
  input  regex_pkg::char_t        char_in,
  input  logic                    char_vld,
  output logic                    fired,
  output regex_pkg::match_count_t count
);

  // Tracker to matcher context
  track_if trk_bus ();

  // Matcher to DFA step path
  dfa_step_if step_bus ();

  // Packet start handling and first-seen table
  stream_tracker #(
    .NUM_STREAMS (NUM_STREAMS)
  ) u_stream_tracker (
    .clk       (clk),
    .rst_n     (rst_n),
    .sop       (sop),
    .stream_id (stream_id),
    .enable    (enable),
    .trk       (trk_bus.source)
  );

  // State save and restore around the DFA, flag and count
  stream_context_matcher #(
    .NUM_STREAMS (NUM_STREAMS)
  ) u_stream_context_matcher (
    .clk      (clk),
    .rst_n    (rst_n),
    .eop      (eop),
    .char_in  (char_in),
    .char_vld (char_vld),
    .trk      (trk_bus.sink),
    .dfa      (step_bus.matcher),
    .fired    (fired),
    .count    (count)
  );

  // Keyword recogniser
  retr_keyword_dfa u_retr_keyword_dfa (
    .clk   (clk),
    .rst_n (rst_n),
    .step  (step_bus.dfa)
  );

endmodule : regex_match_top

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  // 4 ns period
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset held low for the first cycles, released on a falling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire

// ==== verification/regex_match_properties.sv ====
`default_nettype none

module regex_match_properties (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    eop,
  input logic                    load_state,
  input logic                    fired,
  input regex_pkg::match_count_t count
);
  timeunit 1ns;
  timeprecision 1ps;
  import regex_pkg::*;

  // Characters trail sop by at least 4 cycles, so no early match flag
  fired_after_load: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(fired) |-> !($past(load_state, 1) || $past(load_state, 2) || $past(load_state, 3))
  ) else $error("fired rose within 3 cycles of a state load");

  // Count is only touched by eop
  count_after_eop: assert property (
    @(posedge clk) disable iff (!rst_n)
    $changed(count) |-> $past(eop)
  ) else $error("count changed without a preceding eop");

  // One packet adds at most one, wrapping at the top
  count_single_step: assert property (
    @(posedge clk) disable iff (!rst_n)
    $changed(count) |-> (count == match_count_t'($past(count) + 1'b1))
  ) else $error("count moved by more than one");

endmodule : regex_match_properties

// Attach to every instance of the top level
bind regex_match_top regex_match_properties u_properties (
  .clk        (clk),
  .rst_n      (rst_n),
  .eop        (eop),
  .load_state (trk_bus.load_state),
  .fired      (fired),
  .count      (count)
);

`default_nettype wire

// ==== verification/regex_match_tb.sv ====
`default_nettype none

module regex_match_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import regex_pkg::*;

  localparam int NUM_PACKETS    = 300;
  localparam int MAX_PKT_CYCLES = 40;
  localparam int TIMEOUT_NS     = (16 + NUM_PACKETS * MAX_PKT_CYCLES) * 4 + 2000;

  logic         clk;
  logic         rst_n;
  logic         sop;
  logic         eop;
  stream_id_t   stream_id;
  logic         enable;
  char_t        char_in;
  logic         char_vld;
  logic         fired;
  match_count_t count;

  integer seed;

  // Few streams, so that they repeat and interleave
  stream_id_t stream_pool [5] = '{6'd3, 6'd17, 6'd42, 6'd63, 6'd8};
  char_t      keyword     [4] = '{"R", "E", "T", "R"};

  // Reference model state
  keyword_state_e model_state [NUM_STREAMS];
  bit             model_seen  [NUM_STREAMS];
  match_count_t   model_count;

  tb_clock_gen #(.RESET_CYCLES(16)) u_clock_gen (.clk(clk), .rst_n(rst_n));

  regex_match_top #(
    .NUM_STREAMS (NUM_STREAMS)
  ) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .sop       (sop),
    .eop       (eop),
    .stream_id (stream_id),
    .enable    (enable),
    .char_in   (char_in),
    .char_vld  (char_vld),
    .fired     (fired),
    .count     (count)
  );

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_fired(input logic expected);
    if (fired !== expected)
    begin
      $display("FAIL %0t: fired is %b, expected %b", $time, fired, expected);
      abort_run();
    end
  endtask

  task automatic check_count(input match_count_t expected);
    if (count !== expected)
    begin
      $display("FAIL %0t: count is %0d, expected %0d", $time, count, expected);
      abort_run();
    end
  endtask

  // Keyword "retr", any case; the closing 'r' is a hit and drops back to idle
  function automatic keyword_state_e next_keyword_state(input keyword_state_e s,
                                                        input char_t c,
                                                        output bit hit);
    bit is_r;
    bit is_e;
    bit is_t;
    is_r = (c == "r") || (c == "R");
    is_e = (c == "e") || (c == "E");
    is_t = (c == "t") || (c == "T");
    hit  = 1'b0;
    case (s)
      KW_R:    return is_e ? KW_RE : (is_r ? KW_R : KW_IDLE);
      KW_RE:   return is_t ? KW_RET : (is_r ? KW_R : KW_IDLE);
      KW_RET:
      begin
        hit = is_r;
        return KW_IDLE;
      end
      default: return is_r ? KW_R : KW_IDLE;
    endcase
  endfunction

  // Byte mostly taken from the keyword at a running phase, random case
  function automatic char_t pick_byte(input int pos);
    int    sel;
    char_t c;
    sel = $unsigned($random(seed)) % 8;
    if (sel < 6)
      c = keyword[pos % 4];
    else if (sel == 6)
      c = "X";
    else
      c = char_t'($random(seed));
    if (sel < 6 && ($random(seed) & 1) != 0)
      c = c | 8'h20;
    return c;
  endfunction

  // One packet: drive it and step the model alongside, starting at a falling edge
  task automatic run_packet();
    stream_id_t     id;
    logic           en;
    int             len;
    int             phase;
    char_t          c;
    keyword_state_e st;
    logic           flag;
    bit             hit;
    id    = stream_pool[$unsigned($random(seed)) % 5];
    en    = ($unsigned($random(seed)) % 4) != 0;
    len   = 1 + $unsigned($random(seed)) % 12;
    phase = $unsigned($random(seed)) % 4;
    // A stream's first packet is enabled so its saved state is defined
    if (!model_seen[id])
      en = 1'b1;
    st = model_seen[id] ? model_state[id] : KW_IDLE;
    model_seen[id] = 1'b1;
    flag = 1'b0;

    sop       = 1'b1;
    stream_id = id;
    enable    = en;
    @(negedge clk);
    sop = 1'b0;
    // First byte sampled 4 cycles after sop
    repeat (3) @(negedge clk);

    for (int i = 0; i < len; i++)
    begin
      c        = pick_byte(phase + i);
      char_in  = c;
      char_vld = 1'b1;
      st       = next_keyword_state(st, c, hit);
      if (hit)
        flag = 1'b1;
      @(negedge clk);
      char_vld = 1'b0;
      repeat ($unsigned($random(seed)) % 2) @(negedge clk);
    end

    // eop at least 4 cycles after the last byte
    repeat (3) @(negedge clk);
    eop = 1'b1;
    @(negedge clk);
    eop = 1'b0;
    if (en)
    begin
      model_count    = model_count + match_count_t'(flag);
      model_state[id] = st;
    end
    else
    begin
      flag = 1'b0;
    end
    @(negedge clk);
    check_fired(flag);
    check_count(model_count);
    repeat ($unsigned($random(seed)) % 3) @(negedge clk);
  endtask

  initial
  begin
    sop         = 1'b0;
    eop         = 1'b0;
    stream_id   = '0;
    enable      = 1'b0;
    char_in     = '0;
    char_vld    = 1'b0;
    seed        = 11;
    model_count = '0;
    for (int i = 0; i < NUM_STREAMS; i++)
    begin
      model_state[i] = KW_IDLE;
      model_seen[i]  = 1'b0;
    end

    @(posedge rst_n);
    repeat (2) @(negedge clk);
    // Clean state straight after reset
    check_fired(1'b0);
    check_count('0);

    for (int p = 0; p < NUM_PACKETS; p++)
      run_packet();

    $display("test passed");
    $finish;
  end

  // Watchdog sized from packet count and worst-case packet length
  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the packet sequence did not finish in %0d ns", TIMEOUT_NS);
    abort_run();
  end

endmodule : regex_match_tb

`default_nettype wire

// ==== files.f ====
hw/regex_pkg.sv
hw/dfa_step_if.sv
hw/retr_keyword_dfa.sv
hw/stream_context_matcher.sv
hw/stream_tracker.sv
hw/regex_match_top.sv
verification/tb_clock_gen.sv
verification/regex_match_properties.sv
verification/regex_match_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --timing --assert --timescale 1ns/1ps
TOP       = regex_match_tb
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary -j 0 $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
